// File: tb.f
+incdir+include
logic/mlpPkg.sv
logic/featureLoader.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/resultSerializer.sv
logic/mlpLayer.sv
test/tbClock.sv
test/tbMlpLayer.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f tb.f --top-module tbMlpLayer -o simMlpLayer
./obj_dir/simMlpLayer | tee sim.log

if grep -q ">>> PASS" sim.log; then
	echo "Simulation passed."
else
	echo "Simulation failed, see sim.log."
	exit 1
fi

// File: test/tbMlpLayer.sv
`timescale 1ns/100ps
`include "mlpParams.svh"

module tbMlpLayer
	import mlpPkg::*;
();

	localparam int WaitLimit = 2000;
	localparam int CreditNone = 0;
	localparam int CreditFree = 1;
	localparam int CreditGaps = 2;

	logic clk;
	logic reset;
	logic inValid;
	sample_t inFeature;
	logic inCredit;
	logic outValid;
	sample_t outScore;
	neuronIdx_t outIndex;
	logic outCredit = 1'b0;

	int seed;
	string testName;
	int creditMode;
	int gapList [64];
	scoreVec_t expMem [$]; // Expected score vectors in send order.
	int vectorsSent;
	int creditsReturned;
	int grantedTotal;
	int gapIdx;
	int gapLeft;
	int wordsSeen;
	int vecOut;
	int wordPos;

	tbClock uClock (.clk(clk));

	mlpLayer u_dut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inFeature(inFeature),
		.inCredit(inCredit),
		.outValid(outValid),
		.outScore(outScore),
		.outIndex(outIndex),
		.outCredit(outCredit)
	);

	// Score is the ReLU of the bias plus all feature-weight products, wrapped to 32 bits.
	function automatic scoreVec_t refScores(input featureVec_t f);
		scoreVec_t r;
		longint sum;
		sample_t low;
		for (int n = 0; n < `NUM_NEURONS; n++)
		begin
			sum = longint'(biasOf(n));
			for (int i = 0; i < `NUM_INPUTS; i++)
				sum = sum + longint'(f[i]) * longint'(weightOf(n, i));
			low = sum[`DATA_WIDTH-1:0]; // Only the low word survives the wrap.
			r[n] = (low < 0) ? '0 : low;
		end
		return r;
	endfunction

	function automatic featureVec_t randomVector(input logic wide);
		featureVec_t v;
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			if (wide)
				v[i] = $random(seed); // Full range, so the sums overflow.
			else
				v[i] = $random(seed) % 4096;
		end
		return v;
	endfunction

	// Features against the sign of every weight drive neuron n far below zero.
	function automatic featureVec_t opposeVector(input int n);
		featureVec_t v;
		for (int i = 0; i < `NUM_INPUTS; i++)
			v[i] = (weightOf(n, i) > 0) ? -32'sd1000 : 32'sd1000;
		return v;
	endfunction

	function automatic int creditsLeft();
		return `VEC_SLOTS + creditsReturned - vectorsSent;
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "Test %s stopped.", testName);
	endtask

	task automatic checkScore(input sample_t expected, input sample_t actual);
		if (actual !== expected)
			failRun($sformatf("Error: %s: score expected %0d, actual %0d",
				testName, expected, actual));
	endtask

	task automatic checkIndex(input neuronIdx_t expected, input neuronIdx_t actual);
		if (actual !== expected)
			failRun($sformatf("Error: %s: index expected %0d, actual %0d",
				testName, expected, actual));
	endtask

	task automatic checkCount(input int expected, input int actual, input string what);
		if (actual != expected)
			failRun($sformatf("Error: %s: %s expected %0d, actual %0d",
				testName, what, expected, actual));
	endtask

	// Called 1 ns after a rising edge, returns at the same phase.
	task automatic sendVector(input featureVec_t v);
		int cycles;
		cycles = 0;
		while (creditsLeft() == 0)
		begin
			if (cycles >= WaitLimit)
				failRun("Timeout: no input credit came back for the next vector.");
			else
			begin
				@(posedge clk);
				#1;
				cycles++;
			end
		end
		expMem.push_back(refScores(v));
		vectorsSent++;
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			inValid = 1'b1;
			inFeature = v[i];
			@(posedge clk);
			#1;
		end
		inValid = 1'b0;
	endtask

	task automatic waitDrain();
		int cycles;
		cycles = 0;
		while (vecOut != expMem.size())
		begin
			if (cycles >= WaitLimit)
				failRun($sformatf("Timeout: %s still waits for %0d score vectors.",
					testName, expMem.size() - vecOut));
			else
			begin
				@(posedge clk);
				#1;
				cycles++;
			end
		end
	endtask

	// Receiver grants at most one credit per expected word.
	always @(posedge clk)
	begin
		#1;
		outCredit = 1'b0;
		if (reset)
		begin
			grantedTotal = 0;
			gapIdx = 0;
			gapLeft = 0;
		end
		else if (grantedTotal < expMem.size() * `NUM_NEURONS)
		begin
			if (creditMode == CreditFree)
			begin
				outCredit = 1'b1;
				grantedTotal++;
			end
			else if (creditMode == CreditGaps)
			begin
				if (gapLeft == 0)
				begin
					outCredit = 1'b1;
					grantedTotal++;
					gapLeft = gapList[gapIdx];
					gapIdx = (gapIdx + 1) % 64;
				end
				else
					gapLeft--;
			end
		end
	end

	always @(negedge clk)
	begin
		if (reset)
		begin
			creditsReturned = 0;
			wordsSeen = 0;
			vecOut = 0;
			wordPos = 0;
		end
		else
		begin
			if (inCredit)
				creditsReturned++;
			if (outValid)
			begin
				if (wordsSeen >= grantedTotal)
					failRun("outValid went high without an unused output credit.");
				else if (vecOut >= expMem.size())
					failRun("outValid went high with no score vector outstanding.");
				else
				begin
					checkIndex(neuronIdx_t'(wordPos), outIndex);
					checkScore(expMem[vecOut][wordPos], outScore);
					wordsSeen++;
					wordPos++;
					if (wordPos == `NUM_NEURONS)
					begin
						wordPos = 0;
						vecOut++;
					end
				end
			end
		end
	end

	initial
	begin
		int accepted;
		int settle;
		seed = 32'hb022d8f8;
		testName = "reset";
		creditMode = CreditNone;
		vectorsSent = 0;
		reset = 1'b1;
		inValid = 1'b0;
		inFeature = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int c = 0; c < 20; c++)
		begin
			@(negedge clk);
			if (outValid !== 1'b0 || inCredit !== 1'b0)
				failRun("outValid or inCredit went high after reset with no traffic.");
		end
		@(posedge clk);
		#1;

		testName = "single vector";
		creditMode = CreditFree;
		sendVector(randomVector(1'b0));
		waitDrain();

		testName = "relu clamp";
		for (int n = 0; n < `NUM_NEURONS; n++)
			sendVector(opposeVector(n));
		repeat (3) sendVector(randomVector(1'b1));
		waitDrain();

		testName = "input credits";
		repeat (20) sendVector(randomVector(1'b0));
		waitDrain();
		checkCount(vectorsSent, creditsReturned, "inCredit pulses");

		testName = "back-pressure";
		creditMode = CreditNone;
		for (int g = 0; g < 64; g++)
			gapList[g] = {$random(seed)} % 8;
		accepted = 0;
		settle = 0;
		while (settle < 10 && accepted <= 4 * `VEC_SLOTS)
		begin
			if (creditsLeft() > 0)
			begin
				sendVector(randomVector(1'b0));
				accepted++;
				settle = 0;
			end
			else
			begin
				@(posedge clk);
				#1;
				settle++;
			end
		end
		checkCount(2 * `VEC_SLOTS, accepted, "vectors accepted with outputs blocked");
		creditMode = CreditGaps;
		waitDrain();
		checkCount(vectorsSent, creditsReturned, "inCredit pulses");

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: test/tbClock.sv
`timescale 1ns/100ps

module tbClock
(
	output logic clk
);

	initial
		clk = 1'b0;

	always
		#20 clk = ~clk; // 40 ns period.

endmodule

// File: logic/mlpLayer.sv
`timescale 1ns/100ps

module mlpLayer
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input sample_t inFeature,
	output logic inCredit,
	output logic outValid,
	output sample_t outScore,
	output neuronIdx_t outIndex,
	input logic outCredit
);

	logic vecValid;
	featureVec_t vecData;
	logic scoreValid;
	scoreVec_t scoreData;
	logic slotFree;

	featureLoader uLoader (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inFeature(inFeature),
		.slotFree(slotFree),
		.inCredit(inCredit),
		.vecValid(vecValid),
		.vecData(vecData)
	);

	denseLayer uLayer (
		.clk(clk),
		.reset(reset),
		.vecValid(vecValid),
		.vecData(vecData),
		.scoreValid(scoreValid),
		.scoreData(scoreData)
	);

	resultSerializer uSerializer (
		.clk(clk),
		.reset(reset),
		.scoreValid(scoreValid),
		.scoreData(scoreData),
		.outCredit(outCredit),
		.outValid(outValid),
		.outScore(outScore),
		.outIndex(outIndex),
		.slotFree(slotFree)
	);

endmodule

// File: logic/resultSerializer.sv
`timescale 1ns/100ps
`include "mlpParams.svh"

module resultSerializer
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic scoreValid,
	input scoreVec_t scoreData,
	input logic outCredit,
	output logic outValid,
	output sample_t outScore,
	output neuronIdx_t outIndex,
	output logic slotFree
);

	localparam int PtrWidth = $clog2(`VEC_SLOTS);
	localparam int CreditWidth = 16; // Room for a receiver that grants far ahead.
	localparam neuronIdx_t LastIdx = neuronIdx_t'(`NUM_NEURONS - 1);

	scoreVec_t slotMem [`VEC_SLOTS];
	logic [`VEC_SLOTS-1:0] slotFull;
	logic [PtrWidth-1:0] wrSlot;
	logic [PtrWidth-1:0] rdSlot;
	neuronIdx_t wordIdx;
	logic [CreditWidth-1:0] outCredits;

	assign outValid = slotFull[rdSlot] && (outCredits != '0);
	assign outScore = slotMem[rdSlot][wordIdx];
	assign outIndex = wordIdx;
	assign slotFree = outValid && (wordIdx == LastIdx); // Returns a layer credit to the loader.

	always_ff @(posedge clk)
	begin
		if (scoreValid)
			slotMem[wrSlot] <= scoreData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			slotFull <= '0;
			wrSlot <= '0;
			rdSlot <= '0;
			wordIdx <= '0;
			outCredits <= '0;
		end
		else
		begin
			if (scoreValid)
			begin
				slotFull[wrSlot] <= 1'b1; // A slot is always free here, by layer credits.
				wrSlot <= wrSlot + 1'b1;
			end
			if (outValid)
			begin
				if (wordIdx == LastIdx)
				begin
					wordIdx <= '0;
					slotFull[rdSlot] <= 1'b0;
					rdSlot <= rdSlot + 1'b1;
				end
				else
					wordIdx <= wordIdx + 1'b1;
			end
			case ({outCredit, outValid})
				2'b10: outCredits <= outCredits + 1'b1;
				2'b01: outCredits <= outCredits - 1'b1;
				default: outCredits <= outCredits;
			endcase
		end
	end

endmodule

// File: logic/denseLayer.sv
`timescale 1ns/100ps
`include "mlpParams.svh"

module denseLayer
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic vecValid,
	input featureVec_t vecData,
	output logic scoreValid,
	output scoreVec_t scoreData
);

	logic [`NODE_LATENCY-1:0] validPipe; // Tracks the node stages, up to three vectors in flight.

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[`NODE_LATENCY-2:0], vecValid};
	end

	assign scoreValid = validPipe[`NODE_LATENCY-1];

	for (genvar n = 0; n < `NUM_NEURONS; n++)
	begin : gNode
		neuronNode #(.NODE(n)) uNode (
			.clk(clk),
			.reset(reset),
			.vecData(vecData),
			.score(scoreData[n])
		);
	end

endmodule

// File: logic/neuronNode.sv
`timescale 1ns/100ps
`include "mlpParams.svh"

module neuronNode
	import mlpPkg::*;
#(
	parameter int NODE = 0
)
(
	input logic clk,
	input logic reset,
	input featureVec_t vecData,
	output sample_t score
);

	featureVec_t featReg;
	sample_t sumReg;
	sample_t acc;

	// Products and sum are kept at 32 bits, so overflow wraps.
	always_comb
	begin
		acc = biasOf(NODE);
		for (int i = 0; i < `NUM_INPUTS; i++)
			acc = acc + featReg[i] * weightOf(NODE, i);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featReg <= '0;
			sumReg <= '0;
			score <= '0;
		end
		else
		begin
			featReg <= vecData;
			sumReg <= acc;
			if (sumReg[`DATA_WIDTH-1])
				score <= '0; // ReLU clamps negative sums.
			else
				score <= sumReg;
		end
	end

endmodule

// File: logic/featureLoader.sv
`timescale 1ns/100ps
`include "mlpParams.svh"

module featureLoader
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input sample_t inFeature,
	input logic slotFree,
	output logic inCredit,
	output logic vecValid,
	output featureVec_t vecData
);

	localparam int CntWidth = $clog2(`NUM_INPUTS);
	localparam int PtrWidth = $clog2(`VEC_SLOTS);
	localparam int CreditWidth = $clog2(`VEC_SLOTS + 1);
	localparam logic [CntWidth-1:0] LastWord = CntWidth'(`NUM_INPUTS - 1);

	featureVec_t slotMem [`VEC_SLOTS];
	logic [`VEC_SLOTS-1:0] slotFull;
	logic [PtrWidth-1:0] wrSlot;
	logic [PtrWidth-1:0] rdSlot;
	logic [CntWidth-1:0] wordCnt;
	logic [CreditWidth-1:0] layerCredits;

	assign vecValid = slotFull[rdSlot] && (layerCredits != '0); // Layer never stalls.
	assign vecData = slotMem[rdSlot];
	assign inCredit = vecValid; // The issued slot is free for the sender again.

	always_ff @(posedge clk)
	begin
		if (inValid)
			slotMem[wrSlot][wordCnt] <= inFeature;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			slotFull <= '0;
			wrSlot <= '0;
			rdSlot <= '0;
			wordCnt <= '0;
			layerCredits <= CreditWidth'(`VEC_SLOTS);
		end
		else
		begin
			if (vecValid)
			begin
				slotFull[rdSlot] <= 1'b0;
				rdSlot <= rdSlot + 1'b1;
			end
			if (inValid)
			begin
				if (wordCnt == LastWord)
				begin
					wordCnt <= '0;
					slotFull[wrSlot] <= 1'b1; // Vector complete, issue from next cycle.
					wrSlot <= wrSlot + 1'b1;
				end
				else
					wordCnt <= wordCnt + 1'b1;
			end
			case ({slotFree, vecValid})
				2'b10: layerCredits <= layerCredits + 1'b1;
				2'b01: layerCredits <= layerCredits - 1'b1;
				default: layerCredits <= layerCredits;
			endcase
		end
	end

endmodule

// File: logic/mlpPkg.sv
`include "mlpParams.svh"

package mlpPkg;

	typedef logic signed [`DATA_WIDTH-1:0] sample_t;
	typedef sample_t [`NUM_INPUTS-1:0] featureVec_t; // Element 0 is the first word received.
	typedef sample_t [`NUM_NEURONS-1:0] scoreVec_t;
	typedef logic [$clog2(`NUM_NEURONS)-1:0] neuronIdx_t;

	localparam sample_t weightTable [`NUM_NEURONS][`NUM_INPUTS] = '{
		'{1204, -3311, 2745, -987, 4102, -2256, 613, -1840,
			3379, 2901, -4455, 1532, -702, 2088, -1169},
		'{-1876, 4420, 903, -2637, -1195, 5318, -3042, 1477,
			688, -2210, 3864, -956, 2417, -3508, 1721},
		'{3055, -742, -4189, 2264, 1398, -1623, 4770, -2981,
			-517, 1846, -1342, 3627, -2085, 1110, 2543},
		'{-2837, 2652, -2590, 1857, 6880, 1388, 1750, 7235,
			-4980, 1260, 735, 2179, 1648, -1597, -3867}
	};

	localparam sample_t biasTable [`NUM_NEURONS] = '{-150, 275, -320, 480};

	function automatic sample_t weightOf(input int neuron, input int idx);
		return weightTable[neuron][idx];
	endfunction

	function automatic sample_t biasOf(input int neuron);
		return biasTable[neuron];
	endfunction

endpackage

// File: include/mlpParams.svh
`ifndef MLP_PARAMS_SVH
`define MLP_PARAMS_SVH

// Width of every feature, weight and score.
`define DATA_WIDTH 32

// Features per vector.
`define NUM_INPUTS 15

// Neurons in the layer, so also scores per vector.
`define NUM_NEURONS 4

// Vector slots in the loader and the serializer, and the initial credit count on both sides.
`define VEC_SLOTS 2

// Cycles from vecValid to scoreValid through the neuron pipeline.
`define NODE_LATENCY 3

`endif
